//--- source/rvIsaPkg.sv
package rvIsaPkg;

    // Datapath and address width
    localparam int xlen = 32;

    // x0 to x31
    localparam int regAddrWidth = 5;

    // Major opcodes, instruction bits 6:0
    typedef enum logic [6:0] {
        opRType  = 7'b0110011, // add, sub, and, or, slt
        opIType  = 7'b0010011, // addi only
        opLoad   = 7'b0000011, // lw
        opStore  = 7'b0100011, // sw
        opBranch = 7'b1100011  // beq
    } opcodeT;

    // Funct codes as {instruction[30], funct3}
    localparam logic [3:0] functAdd = 4'b0000;
    localparam logic [3:0] functSub = 4'b1000;
    localparam logic [3:0] functSlt = 4'b0010;
    localparam logic [3:0] functOr  = 4'b0110;
    localparam logic [3:0] functAnd = 4'b0111;

endpackage

//--- source/cpuCtrlPkg.sv
package cpuCtrlPkg;

    // Operations the ALU understands
    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluSlt = 4'd4
    } aluOpT;

    // What the main decoder tells the ALU decoder
    typedef enum logic [1:0] {
        classMem    = 2'd0, // Address calculation by add
        classBranch = 2'd1, // beq compare by subtraction
        classFunct  = 2'd2  // Look at funct bits
    } aluClassT;

    // Memory depths in words
    localparam int imemWords = 64;
    localparam int dmemWords = 64;

    // Program image for the instruction ROM
    localparam imemFile = "tests/program.hex";

endpackage

//--- source/programCounter.sv
`timescale 1ns/1ns

module programCounter
    import rvIsaPkg::*;
(
    input  logic            CLK,
    input  logic            reset,
    input  logic [xlen-1:0] immediate,  // B immediate in half-words
    input  logic            takeBranch,
    output logic [xlen-1:0] pc
);

    logic [xlen-1:0] pcPlus4;
    logic [xlen-1:0] branchTarget;
    logic [xlen-1:0] nextPc;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pc + {immediate[xlen-2:0], 1'b0}; // Back to a byte offset

    assign nextPc = takeBranch ? branchTarget : pcPlus4;

    always_ff @(posedge CLK) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

//--- source/instructionMemory.sv
`timescale 1ns/1ns

module instructionMemory
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic [xlen-1:0] pc,
    output logic [xlen-1:0] instruction
);

    logic [xlen-1:0]                rom [imemWords];
    logic [$clog2(imemWords)-1:0]   wordIndex;
    logic                           inRange;

    initial begin
        for (int i = 0; i < imemWords; i++) begin
            rom[i] = '0; // Words past the program stay zero
        end
        $readmemh(imemFile, rom);
    end

    assign wordIndex = pc[$clog2(imemWords)+1:2];
    assign inRange   = (pc[xlen-1:$clog2(imemWords)+2] == '0);

    assign instruction = inRange ? rom[wordIndex] : '0;

endmodule

//--- source/registerFile.sv
`timescale 1ns/1ns

module registerFile
    import rvIsaPkg::*;
(
    input  logic                    CLK,
    input  logic                    reset,
    input  logic [regAddrWidth-1:0] rs1,
    input  logic [regAddrWidth-1:0] rs2,
    input  logic [regAddrWidth-1:0] rd,
    input  logic [xlen-1:0]         writeData,
    input  logic                    regWrite,
    output logic [xlen-1:0]         readData1,
    output logic [xlen-1:0]         readData2
);

    logic [xlen-1:0] regs [2**regAddrWidth];

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && rd != '0) begin
            regs[rd] <= writeData; // x0 is never written
        end
    end

    // x0 is hardwired to zero
    assign readData1 = (rs1 == '0) ? '0 : regs[rs1];
    assign readData2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- source/dataMemory.sv
`timescale 1ns/1ns

module dataMemory
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic            CLK,
    input  logic            reset,
    input  logic [xlen-1:0] address,   // Byte address, word aligned
    input  logic [xlen-1:0] storeData,
    input  logic            memWrite,
    output logic [xlen-1:0] loadData
);

    logic [xlen-1:0]              ram [dmemWords];
    logic [$clog2(dmemWords)-1:0] wordIndex;

    assign wordIndex = address[$clog2(dmemWords)+1:2];

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < dmemWords; i++) begin
                ram[i] <= '0;
            end
        end else if (memWrite) begin
            ram[wordIndex] <= storeData;
        end
    end

    assign loadData = ram[wordIndex];

endmodule

//--- source/immediateGenerator.sv
`timescale 1ns/1ns

module immediateGenerator
    import rvIsaPkg::*;
(
    input  logic [xlen-1:0] instruction,
    output logic [xlen-1:0] immediate
);

    // Twelve payload bits with instruction bit 31 on top
    logic [11:0] rawImm;

    always_comb begin
        case (opcodeT'(instruction[6:0]))
            opIType, opLoad: begin
                rawImm = instruction[31:20];
            end
            opStore: begin
                rawImm = {instruction[31:25], instruction[11:7]};
            end
            opBranch: begin
                // imm[12:1] without the low zero
                rawImm = {instruction[31], instruction[7], instruction[30:25], instruction[11:8]};
            end
            default: begin
                rawImm = '0;
            end
        endcase
    end

    assign immediate = {{(xlen-12){rawImm[11]}}, rawImm};

endmodule

//--- source/controlUnit.sv
`timescale 1ns/1ns

module controlUnit
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic       reset,
    input  opcodeT     opcode,
    input  logic [3:0] funct,    // {bit 30, funct3}
    output logic       regWrite,
    output logic       aluSrc,
    output logic       memWrite,
    output logic       memToReg,
    output logic       branch,
    output aluOpT      aluOp
);

    aluClassT aluClass;

    // Main decoder
    always_comb begin
        regWrite = 1'b0;
        aluSrc   = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        branch   = 1'b0;
        aluClass = classMem;

        case (opcode)
            opRType: begin
                regWrite = 1'b1;
                aluClass = classFunct;
            end
            opIType: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1; // Bit 30 plays no part in addi
            end
            opLoad: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                memToReg = 1'b1;
            end
            opStore: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            opBranch: begin
                branch   = 1'b1;
                aluClass = classBranch; // Equal operands give zero
            end
            default: begin
            end
        endcase

        if (reset) begin
            regWrite = 1'b0;
            memWrite = 1'b0;
        end
    end

    // ALU decoder
    always_comb begin
        case (aluClass)
            classMem:    aluOp = aluAdd;
            classBranch: aluOp = aluSub;
            classFunct: begin
                case (funct)
                    functAdd: aluOp = aluAdd;
                    functSub: aluOp = aluSub;
                    functAnd: aluOp = aluAnd;
                    functOr:  aluOp = aluOr;
                    functSlt: aluOp = aluSlt;
                    default:  aluOp = aluAdd;
                endcase
            end
            default: aluOp = aluAdd;
        endcase
    end

endmodule

//--- source/alu.sv
`timescale 1ns/1ns

module alu
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic [xlen-1:0] operandA,
    input  logic [xlen-1:0] operandB,
    input  aluOpT           aluOp,
    output logic [xlen-1:0] result,
    output logic            zero
);

    logic lessThan;

    // Signed compare for slt
    assign lessThan = $signed(operandA) < $signed(operandB);

    always_comb begin
        case (aluOp)
            aluAdd:  result = operandA + operandB;
            aluSub:  result = operandA - operandB;
            aluAnd:  result = operandA & operandB;
            aluOr:   result = operandA | operandB;
            aluSlt:  result = {{(xlen-1){1'b0}}, lessThan};
            default: result = '0;
        endcase
    end

    assign zero = (result == '0); // Used by beq

endmodule

//--- source/singleCpu.sv
`timescale 1ns/1ns

module singleCpu
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic                    CLK,
    input  logic                    reset,
    output logic [xlen-1:0]         pc,
    output logic [xlen-1:0]         instruction,
    output logic                    regWrite,
    output logic [regAddrWidth-1:0] writeReg,
    output logic [xlen-1:0]         writeData
);

    // Instruction fields
    opcodeT                  opcode;
    logic [regAddrWidth-1:0] rs1;
    logic [regAddrWidth-1:0] rs2;
    logic [3:0]              funct;

    logic [xlen-1:0] readData1;
    logic [xlen-1:0] readData2;
    logic [xlen-1:0] immediate;
    logic [xlen-1:0] operandB;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] readData; // From data memory
    logic            zero;

    // Control
    logic  aluSrc;
    logic  memWrite;
    logic  memToReg;
    logic  branch;
    logic  takeBranch;
    aluOpT aluOp;

    assign opcode   = opcodeT'(instruction[6:0]);
    assign rs1      = instruction[19:15];
    assign rs2      = instruction[24:20];
    assign writeReg = instruction[11:7];
    assign funct    = {instruction[30], instruction[14:12]};

    assign operandB   = aluSrc ? immediate : readData2;
    assign writeData  = memToReg ? readData : aluResult;
    assign takeBranch = branch & zero; // beq taken

    programCounter programCounter1 (
        .CLK(CLK), .reset(reset), .immediate(immediate), .takeBranch(takeBranch), .pc(pc)
    );

    instructionMemory instructionMemory1 (.pc(pc), .instruction(instruction));

    registerFile registerFile1 (
        .CLK(CLK), .reset(reset), .rs1(rs1), .rs2(rs2), .rd(writeReg),
        .writeData(writeData), .regWrite(regWrite),
        .readData1(readData1), .readData2(readData2)
    );

    dataMemory dataMemory1 (
        .CLK(CLK), .reset(reset), .address(aluResult), .storeData(readData2),
        .memWrite(memWrite), .loadData(readData)
    );

    immediateGenerator immediateGenerator1 (.instruction(instruction), .immediate(immediate));

    controlUnit controlUnit1 (
        .reset(reset), .opcode(opcode), .funct(funct), .regWrite(regWrite),
        .aluSrc(aluSrc), .memWrite(memWrite), .memToReg(memToReg),
        .branch(branch), .aluOp(aluOp)
    );

    alu alu1 (
        .operandA(readData1), .operandB(operandB), .aluOp(aluOp),
        .result(aluResult), .zero(zero)
    );

endmodule

//--- tests/singleCpuTb.sv
`timescale 1ns/1ns

module singleCpuTb
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
();

    localparam int clkPeriod   = 4;
    localparam int resetCycles = 3;
    localparam int numRows     = 22;
    localparam int timeoutNs   = (numRows + resetCycles + 10) * clkPeriod;

    // One retired instruction per row
    typedef struct packed {
        logic [xlen-1:0]         pc;
        logic [xlen-1:0]         instruction;
        logic                    regWrite;
        logic [regAddrWidth-1:0] writeReg;
        logic [xlen-1:0]         writeData;
    } traceRowT;

    logic                    CLK;
    logic                    reset;
    logic [xlen-1:0]         pc;
    logic [xlen-1:0]         instruction;
    logic                    regWrite;
    logic [regAddrWidth-1:0] writeReg;
    logic [xlen-1:0]         writeData;

    traceRowT trace [numRows];

    singleCpu i_singleCpu (
        .CLK(CLK), .reset(reset), .pc(pc), .instruction(instruction),
        .regWrite(regWrite), .writeReg(writeReg), .writeData(writeData)
    );

    initial begin
        CLK = 1'b0;
        forever #(clkPeriod / 2) CLK = ~CLK;
    end

    initial begin
        #(timeoutNs);
        $display("Timeout after %0d ns, the program trace did not complete", timeoutNs);
        $display("Simulation FAILED");
        $fatal(1, "Watchdog expired");
    end

    task automatic checkWord(input string name, input logic [xlen-1:0] expected,
                             input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Register indices and the write flag
    task automatic checkIndex(input string name, input logic [regAddrWidth-1:0] expected,
                              input logic [regAddrWidth-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s expected 0x%h actual 0x%h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // pc, instruction, regWrite, writeReg, writeData
    task automatic fillTrace();
        trace[0]  = '{32'h0000_0000, 32'h0070_0093, 1'b1, 5'd1,  32'h0000_0007};
        trace[1]  = '{32'h0000_0004, 32'hFFA0_0113, 1'b1, 5'd2,  32'hFFFF_FFFA}; // Negative imm
        trace[2]  = '{32'h0000_0008, 32'h0020_81B3, 1'b1, 5'd3,  32'h0000_0001};
        trace[3]  = '{32'h0000_000C, 32'h4020_8233, 1'b1, 5'd4,  32'h0000_000D};
        trace[4]  = '{32'h0000_0010, 32'h0020_F2B3, 1'b1, 5'd5,  32'h0000_0002};
        trace[5]  = '{32'h0000_0014, 32'h0020_E333, 1'b1, 5'd6,  32'hFFFF_FFFF};
        trace[6]  = '{32'h0000_0018, 32'h0011_23B3, 1'b1, 5'd7,  32'h0000_0001}; // -6 < 7
        trace[7]  = '{32'h0000_001C, 32'h0020_A433, 1'b1, 5'd8,  32'h0000_0000};
        // Stores show the address on writeData
        trace[8]  = '{32'h0000_0020, 32'h0010_2023, 1'b0, 5'd0,  32'h0000_0000};
        trace[9]  = '{32'h0000_0024, 32'h0020_2423, 1'b0, 5'd8,  32'h0000_0008};
        trace[10] = '{32'h0000_0028, 32'h0000_2483, 1'b1, 5'd9,  32'h0000_0007};
        trace[11] = '{32'h0000_002C, 32'h0080_2503, 1'b1, 5'd10, 32'hFFFF_FFFA};
        trace[12] = '{32'h0000_0030, 32'h0040_2583, 1'b1, 5'd11, 32'h0000_0000}; // Never written
        trace[13] = '{32'h0000_0034, 32'h0020_8463, 1'b0, 5'd8,  32'h0000_000D}; // Not taken
        trace[14] = '{32'h0000_0038, 32'h0014_8463, 1'b0, 5'd8,  32'h0000_0000}; // Skips 0x3C
        trace[15] = '{32'h0000_0040, 32'h0110_0013, 1'b1, 5'd0,  32'h0000_0011}; // Write to x0
        trace[16] = '{32'h0000_0044, 32'h0010_06B3, 1'b1, 5'd13, 32'h0000_0007};
        trace[17] = '{32'h0000_0048, 32'h0000_0663, 1'b0, 5'd12, 32'h0000_0000};
        trace[18] = '{32'h0000_0054, 32'hFE00_0CE3, 1'b0, 5'd25, 32'h0000_0000}; // Backward
        trace[19] = '{32'h0000_004C, 32'h0210_0713, 1'b1, 5'd14, 32'h0000_0021};
        trace[20] = '{32'h0000_0050, 32'h0000_0663, 1'b0, 5'd12, 32'h0000_0000}; // Skips 0x58
        trace[21] = '{32'h0000_005C, 32'h00D7_07B3, 1'b1, 5'd15, 32'h0000_0028};
    endtask

    initial begin
        reset = 1'b1;
        fillTrace();
        // Held reset state once the first edge has cleared pc
        repeat (resetCycles - 1) begin
            @(negedge CLK);
            #1;
            checkWord("pc", '0, pc);
            checkIndex("regWrite", '0, regAddrWidth'(regWrite));
        end
        @(negedge CLK);
        reset = 1'b0;
        for (int i = 0; i < numRows; i++) begin
            #1; // One ns before the rising edge
            checkWord("pc", trace[i].pc, pc);
            checkWord("instruction", trace[i].instruction, instruction);
            checkIndex("regWrite", regAddrWidth'(trace[i].regWrite), regAddrWidth'(regWrite));
            checkIndex("writeReg", trace[i].writeReg, writeReg);
            checkWord("writeData", trace[i].writeData, writeData);
            @(negedge CLK);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- tests/program.hex
// Instruction word in hex per line, word 0 at pc 0x00, then byte pc and assembly
00700093 // 0x00 addi x1, x0, 7
FFA00113 // 0x04 addi x2, x0, -6
002081B3 // 0x08 add  x3, x1, x2
40208233 // 0x0C sub  x4, x1, x2
0020F2B3 // 0x10 and  x5, x1, x2
0020E333 // 0x14 or   x6, x1, x2
001123B3 // 0x18 slt  x7, x2, x1
0020A433 // 0x1C slt  x8, x1, x2
00102023 // 0x20 sw   x1, 0(x0)
00202423 // 0x24 sw   x2, 8(x0)
00002483 // 0x28 lw   x9, 0(x0)
00802503 // 0x2C lw   x10, 8(x0)
00402583 // 0x30 lw   x11, 4(x0)
00208463 // 0x34 beq  x1, x2, +8
00148463 // 0x38 beq  x9, x1, +8
06300613 // 0x3C addi x12, x0, 99
01100013 // 0x40 addi x0, x0, 17
001006B3 // 0x44 add  x13, x0, x1
00000663 // 0x48 beq  x0, x0, +12
02100713 // 0x4C addi x14, x0, 33
00000663 // 0x50 beq  x0, x0, +12
FE000CE3 // 0x54 beq  x0, x0, -8
04D00813 // 0x58 addi x16, x0, 77
00D707B3 // 0x5C add  x15, x14, x13

//--- singleCpu.f
source/rvIsaPkg.sv
source/cpuCtrlPkg.sv
source/programCounter.sv
source/instructionMemory.sv
source/registerFile.sv
source/dataMemory.sv
source/immediateGenerator.sv
source/controlUnit.sv
source/alu.sv
source/singleCpu.sv
tests/singleCpuTb.sv

//--- runSim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary -f singleCpu.f --top-module singleCpuTb -o singleCpuSim \
    && ./obj_dir/singleCpuSim | grep "Simulation PASSED" \
    || exit 1
